/* project.f */
logic/math_pkg.sv
logic/vertex_pkg.sv
logic/divu.sv
logic/triangle_projector.sv
logic/viewport_mapper.sv
logic/projection_unit.sv
verification/projection_checker.sv
verification/projection_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module projection_tb -f project.f -o projection_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/projection_sim > sim.log 2>&1 || echo "Simulation exited with an error" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0

/* verification/projection_tb.sv */
`timescale 1ns/1ns

module projection_tb;

    localparam math_pkg::q16_16_t CENTER_X = 32'sh00a0_0000;    // 160.0
    localparam math_pkg::q16_16_t CENTER_Y = 32'sh0078_0000;    // 120.0
    localparam int N_TRIANGLES    = 60;     // Upper bound over all tests
    localparam int CYCLES_PER_TRI = 200;    // Three divides need about 150
    localparam int MAX_CYCLES     = N_TRIANGLES * CYCLES_PER_TRI;

    logic                  clk = 1'b0;
    logic                  rst;
    vertex_pkg::triangle_t in_triangle;
    logic                  in_valid;
    logic                  in_ready;
    math_pkg::q16_16_t     focal_length;
    vertex_pkg::triangle_t out_triangle;
    logic                  out_valid;
    logic                  out_ready = 1'b1;
    logic                  busy;
    int                    seed = 32'hcdb0;
    int                    bp_mode = 0;     // 0 always ready, 1 random, 2 held low
    int                    cycles = 0;
    int                    err_mark;
    int                    match_mark;

    always #5 clk = ~clk;

    projection_unit #(
        .CENTER_X (CENTER_X),
        .CENTER_Y (CENTER_Y)
    ) u_projection_unit (
        .clk          (clk),
        .rst          (rst),
        .in_triangle  (in_triangle),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .focal_length (focal_length),
        .out_triangle (out_triangle),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .busy         (busy)
    );

    projection_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .out_triangle (out_triangle),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

    function automatic math_pkg::q16_16_t q16(input int n);
        return math_pkg::q16_16_t'(n) <<< math_pkg::Q_FRAC;
    endfunction

    function automatic vertex_pkg::vertex_t make_vertex(
        input math_pkg::q16_16_t x, y, z,
        input logic [23:0]       rgb
    );
        vertex_pkg::vertex_t v;

        v.pos.x = x;
        v.pos.y = y;
        v.pos.z = z;
        v.color = rgb;
        return v;
    endfunction

    // Expected vertex after reciprocal, projection, sign fix and centering
    function automatic vertex_pkg::vertex_t reference_vertex(
        input vertex_pkg::vertex_t v,
        input math_pkg::q16_16_t   f
    );
        logic [31:0]         abs_z;
        logic [63:0]         recip_full;
        math_pkg::q16_16_t   z_inv;
        logic signed [95:0]  fw;
        logic signed [95:0]  px;
        logic signed [95:0]  py;
        vertex_pkg::vertex_t r;

        abs_z = v.pos.z[31] ? 32'(-v.pos.z) : 32'(v.pos.z);
        if (abs_z == 32'd0)
            abs_z = 32'd1;                  // Zero depth counts as one LSB
        recip_full = (64'(math_pkg::Q_ONE) << math_pkg::Q_FRAC) / 64'(abs_z);
        z_inv = recip_full[31:0];           // Only the low word reaches the datapath
        fw = 96'(f);
        px = (fw * 96'(v.pos.x) * 96'(z_inv)) >>> 32;
        py = (fw * 96'(v.pos.y) * 96'(z_inv)) >>> 32;
        r = v;
        r.pos.x = (v.pos.z[31] ? -px[31:0] : px[31:0]) + CENTER_X;
        r.pos.y = (v.pos.z[31] ? -py[31:0] : py[31:0]) + CENTER_Y;
        return r;
    endfunction

    function automatic vertex_pkg::triangle_t reference_triangle(
        input vertex_pkg::triangle_t t,
        input math_pkg::q16_16_t     f
    );
        vertex_pkg::triangle_t r;

        r.v0 = reference_vertex(t.v0, f);
        r.v1 = reference_vertex(t.v1, f);
        r.v2 = reference_vertex(t.v2, f);
        return r;
    endfunction

    function automatic logic is_culled(input vertex_pkg::triangle_t t);
        return (t.v0.pos.z <= 0) && (t.v1.pos.z <= 0) && (t.v2.pos.z <= 0);
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_triangle(input vertex_pkg::triangle_t t, input math_pkg::q16_16_t f);
        while (!in_ready)
            @(negedge clk);
        focal_length = f;                   // Projector idle so the change is safe
        in_triangle  = t;
        in_valid     = 1'b1;
        if (!is_culled(t))
            u_checker.push_expected(reference_triangle(t, f));
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic random_vertex(output vertex_pkg::vertex_t v);
        logic [31:0] pick;

        pick    = $random(seed);
        v.pos.x = math_pkg::q16_16_t'($random(seed)) >>> 9;
        v.pos.y = math_pkg::q16_16_t'($random(seed)) >>> 9;
        if (pick[2:0] == 3'd0)
            v.pos.z = '0;
        else
            v.pos.z = math_pkg::q16_16_t'($random(seed)) >>> 8;
        v.color = pick[31:8];
    endtask

    task automatic random_triangle(output vertex_pkg::triangle_t t, output math_pkg::q16_16_t f);
        vertex_pkg::vertex_t v0;
        vertex_pkg::vertex_t v1;
        vertex_pkg::vertex_t v2;

        random_vertex(v0);
        random_vertex(v1);
        random_vertex(v2);
        t = {v0, v1, v2};
        f = 32'sh0000_8000 + (math_pkg::q16_16_t'($random(seed)) & 32'sh0003_ffff);
    endtask

    task automatic start_test(input string name);
        u_checker.test_name = name;
        err_mark   = u_checker.error_count;
        match_mark = u_checker.match_count;
    endtask

    task automatic finish_test();
        while (busy || out_valid)
            @(negedge clk);
        $display("Test %s done: %0d triangles matched, %0d errors", u_checker.test_name,
                 u_checker.match_count - match_mark, u_checker.error_count - err_mark);
    endtask

    // Downstream readiness
    always @(negedge clk) begin
        logic [31:0] coin;

        if (bp_mode == 1) begin
            coin      = $random(seed);
            out_ready = coin[0];
        end else begin
            out_ready = (bp_mode == 0);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        vertex_pkg::triangle_t t;
        math_pkg::q16_16_t     f;

        rst          = 1'b1;
        in_valid     = 1'b0;
        in_triangle  = '0;
        focal_length = math_pkg::Q_ONE;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset");
        @(negedge clk);
        u_checker.check_flag("in_ready", 1'b1, in_ready);
        u_checker.check_flag("out_valid", 1'b0, out_valid);
        u_checker.check_flag("busy", 1'b0, busy);
        finish_test();

        start_test("known_values");
        t = {make_vertex(q16(1), q16(2), q16(2), 24'hff0000),
             make_vertex(-q16(3), 32'sh0000_8000, q16(4), 24'h00ff00),
             make_vertex(q16(16), -q16(8), q16(1), 24'h0000ff)};
        send_triangle(t, q16(2));
        t = {make_vertex(q16(10), q16(5), q16(8), 24'h123456),
             make_vertex(-q16(7), q16(1), q16(3), 24'h789abc),
             make_vertex(q16(0), -q16(2), 32'sh0000_4000, 24'hdef012)};
        send_triangle(t, 32'sh0001_8000);   // 1.5
        finish_test();

        start_test("negative_depth");
        t = {make_vertex(q16(4), q16(3), -q16(2), 24'h111111),
             make_vertex(q16(5), -q16(6), q16(0), 24'h222222),
             make_vertex(-q16(1), q16(2), q16(4), 24'h333333)};
        send_triangle(t, q16(1));
        t = {make_vertex(-q16(9), q16(7), -q16(4), 24'h444444),
             make_vertex(q16(2), q16(2), -32'sh0000_0001, 24'h555555),
             make_vertex(q16(3), -q16(3), q16(0), 24'h666666)};
        send_triangle(t, q16(3));
        finish_test();

        start_test("culled");
        t = {make_vertex(q16(1), q16(1), -q16(1), 24'h777777),
             make_vertex(q16(2), q16(2), q16(0), 24'h888888),
             make_vertex(q16(3), q16(3), -q16(3), 24'h999999)};
        send_triangle(t, q16(2));
        t = {make_vertex(q16(6), q16(1), q16(2), 24'haaaaaa),
             make_vertex(-q16(4), q16(2), q16(5), 24'hbbbbbb),
             make_vertex(q16(1), -q16(5), q16(3), 24'hcccccc)};
        send_triangle(t, q16(2));
        finish_test();

        // Two triangles fill the mapper and the projector
        start_test("backpressure");
        bp_mode = 2;
        for (int i = 0; i < 10; i++) begin
            t = {make_vertex(q16(i - 4), q16(3 - i), q16(i + 1), 24'(i * 3)),
                 make_vertex(q16(2 * i), -q16(i), q16(2), 24'(i * 5)),
                 make_vertex(-q16(i), q16(i + 2), q16(7 - i), 24'(i * 7))};
            send_triangle(t, q16(1) + math_pkg::q16_16_t'(i * 4096));
            if (i == 1) begin
                repeat (300) begin
                    @(negedge clk);
                    u_checker.check_flag("in_ready while blocked", 1'b0, in_ready);
                end
                bp_mode = 1;
            end
        end
        finish_test();
        bp_mode = 0;

        start_test("random");
        for (int i = 0; i < 40; i++) begin
            random_triangle(t, f);
            send_triangle(t, f);
        end
        finish_test();

        u_checker.report_leftovers();
        $display("Summary: %0d triangles matched, %0d errors",
                 u_checker.match_count, u_checker.error_count);
        if (u_checker.error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* verification/projection_checker.sv */
`timescale 1ns/1ns

module projection_checker (
    input logic                  clk,
    input logic                  rst,
    input vertex_pkg::triangle_t out_triangle,
    input logic                  out_valid,
    input logic                  out_ready
);

    vertex_pkg::triangle_t exp_q[$];        // Oldest expected triangle at the front
    string                 test_name   = "none";
    int                    match_count = 0;
    int                    error_count = 0;

    task automatic push_expected(input vertex_pkg::triangle_t t);
        exp_q.push_back(t);
    endtask

    // Single-bit status check on a DUT port
    task automatic check_flag(input string what, input logic exp_bit, input logic act_bit);
        if (exp_bit !== act_bit) begin
            $display("Error %s: %s expected %0b, actual %0b", test_name, what, exp_bit, act_bit);
            error_count++;
        end
    endtask

    // Each transfer pairs with the head of the queue
    always @(posedge clk) begin
        vertex_pkg::triangle_t expected;

        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected triangle at the output during test %s", test_name);
                error_count++;
            end else begin
                expected = exp_q.pop_front();
                if (out_triangle !== expected) begin
                    $display("Error %s: expected %h, actual %h",
                             test_name, expected, out_triangle);
                    error_count++;
                end else begin
                    match_count++;
                end
            end
        end
    end

    task automatic report_leftovers();
        if (exp_q.size() != 0) begin
            $display("%0d expected triangles never left the DUT", exp_q.size());
            error_count += exp_q.size();
        end
    endtask

endmodule

/* logic/projection_unit.sv */
`timescale 1ns/1ns

module projection_unit #(
    parameter math_pkg::q16_16_t CENTER_X = 32'sh00a0_0000,
    parameter math_pkg::q16_16_t CENTER_Y = 32'sh0078_0000
) (
    input  logic                  clk,
    input  logic                  rst,

    input  vertex_pkg::triangle_t in_triangle,
    input  logic                  in_valid,
    output logic                  in_ready,

    input  math_pkg::q16_16_t     focal_length,   // Hold constant while busy

    output vertex_pkg::triangle_t out_triangle,
    output logic                  out_valid,
    input  logic                  out_ready,

    output logic                  busy
);

    vertex_pkg::triangle_t proj_triangle;
    logic                  proj_valid;
    logic                  proj_ready;
    logic                  proj_busy;
    logic                  map_busy;

    triangle_projector #(
        .DIV_WIDTH (32),
        .DIV_FBITS (math_pkg::Q_FRAC)
    ) u_triangle_projector (
        .clk          (clk),
        .rst          (rst),
        .in_triangle  (in_triangle),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .focal_length (focal_length),
        .out_triangle (proj_triangle),
        .out_valid    (proj_valid),
        .out_ready    (proj_ready),
        .busy         (proj_busy)
    );

    viewport_mapper #(
        .CENTER_X (CENTER_X),
        .CENTER_Y (CENTER_Y)
    ) u_viewport_mapper (
        .clk          (clk),
        .rst          (rst),
        .in_triangle  (proj_triangle),
        .in_valid     (proj_valid),
        .in_ready     (proj_ready),
        .out_triangle (out_triangle),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .busy         (map_busy)
    );

    assign busy = proj_busy || map_busy;

endmodule

/* logic/viewport_mapper.sv */
`timescale 1ns/1ns

module viewport_mapper #(
    parameter math_pkg::q16_16_t CENTER_X = 32'sh00a0_0000,    // 160.0
    parameter math_pkg::q16_16_t CENTER_Y = 32'sh0078_0000     // 120.0
) (
    input  logic                  clk,
    input  logic                  rst,

    input  vertex_pkg::triangle_t in_triangle,
    input  logic                  in_valid,
    output logic                  in_ready,

    output vertex_pkg::triangle_t out_triangle,
    output logic                  out_valid,
    input  logic                  out_ready,

    output logic                  busy
);

    vertex_pkg::triangle_t out_reg;
    vertex_pkg::triangle_t mapped;
    logic                  full;
    logic                  accept;
    logic                  culled;

    function automatic vertex_pkg::vertex_t center_vertex(input vertex_pkg::vertex_t v);
        vertex_pkg::vertex_t r;

        r       = v;
        r.pos.x = v.pos.x + CENTER_X;
        r.pos.y = v.pos.y + CENTER_Y;
        return r;
    endfunction

    // At or behind the camera plane
    function automatic logic behind(input math_pkg::q16_16_t z);
        return z[31] || (z == '0);
    endfunction

    assign in_ready = !full || out_ready;   // Slot frees in the same cycle
    assign accept   = in_valid && in_ready;
    assign culled   = behind(in_triangle.v0.pos.z) && behind(in_triangle.v1.pos.z)
                      && behind(in_triangle.v2.pos.z);

    always_comb begin
        mapped.v0 = center_vertex(in_triangle.v0);
        mapped.v1 = center_vertex(in_triangle.v1);
        mapped.v2 = center_vertex(in_triangle.v2);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            full <= 1'b0;
        else if (accept)
            full <= !culled;                // Culled entry is swallowed
        else if (out_ready)
            full <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept && !culled)
            out_reg <= mapped;
    end

    assign out_triangle = out_reg;
    assign out_valid    = full;
    assign busy         = full;

    a_valid_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid)
        else $error("viewport_mapper: out_valid dropped without out_ready");

endmodule

/* logic/triangle_projector.sv */
`timescale 1ns/1ns

module triangle_projector #(
    parameter int DIV_WIDTH = 32,
    parameter int DIV_FBITS = 16
) (
    input  logic                  clk,
    input  logic                  rst,

    input  vertex_pkg::triangle_t in_triangle,
    input  logic                  in_valid,
    output logic                  in_ready,

    input  math_pkg::q16_16_t     focal_length,

    output vertex_pkg::triangle_t out_triangle,
    output logic                  out_valid,
    input  logic                  out_ready,

    output logic                  busy
);

    typedef enum logic [1:0] {IDLE, DIVIDE, OUTPUT} state_t;

    state_t                state;
    logic [1:0]            vert_idx;        // Vertex under division
    logic                  div_pending;     // Start issued, done not yet seen
    vertex_pkg::triangle_t tri_in_reg;
    vertex_pkg::triangle_t tri_proj_reg;

    logic                  div_start;
    logic                  div_busy;
    logic                  div_done;
    logic [DIV_WIDTH-1:0]  z_abs;
    logic [DIV_WIDTH-1:0]  div_b;
    logic [DIV_WIDTH-1:0]  div_val;
    math_pkg::q16_16_t     z_inv;
    math_pkg::q16_16_t     x_proj;
    math_pkg::q16_16_t     y_proj;
    vertex_pkg::vertex_t   cur_vertex;
    vertex_pkg::vertex_t   proj_vertex;

    assign in_ready  = (state == IDLE);
    assign out_valid = (state == OUTPUT);
    assign busy      = (state != IDLE);
    assign div_start = (state == DIVIDE) && !div_pending && !div_busy;

    // Reciprocal of |z|, 1.0 / |z| in Q16.16
    divu #(
        .WIDTH (DIV_WIDTH),
        .FBITS (DIV_FBITS)
    ) u_divu (
        .clk   (clk),
        .rst   (rst),
        .start (div_start),
        .a     (DIV_WIDTH'(math_pkg::Q_ONE)),
        .b     (div_b),
        .busy  (div_busy),
        .done  (div_done),
        .valid (),
        .dbz   (),
        .ovf   (),
        .val   (div_val)
    );

    assign z_inv = math_pkg::q16_16_t'(div_val);

    always_comb begin
        case (vert_idx)
            2'd0:    cur_vertex = tri_in_reg.v0;
            2'd1:    cur_vertex = tri_in_reg.v1;
            default: cur_vertex = tri_in_reg.v2;
        endcase
        z_abs = cur_vertex.pos.z[31] ? DIV_WIDTH'(-cur_vertex.pos.z)
                                     : DIV_WIDTH'(cur_vertex.pos.z);
        div_b = (z_abs == '0) ? DIV_WIDTH'(1) : z_abs;  // Zero depth becomes one LSB
    end

    // Divider saw |z|, so the sign of z comes back here
    always_comb begin
        x_proj = math_pkg::project_q16_16(focal_length, cur_vertex.pos.x, z_inv);
        y_proj = math_pkg::project_q16_16(focal_length, cur_vertex.pos.y, z_inv);
        proj_vertex.pos.x = cur_vertex.pos.z[31] ? -x_proj : x_proj;
        proj_vertex.pos.y = cur_vertex.pos.z[31] ? -y_proj : y_proj;
        proj_vertex.pos.z = cur_vertex.pos.z;
        proj_vertex.color = cur_vertex.color;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            vert_idx    <= 2'd0;
            div_pending <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (in_valid) begin
                        state    <= DIVIDE;
                        vert_idx <= 2'd0;
                    end
                end
                DIVIDE: begin
                    if (div_start)
                        div_pending <= 1'b1;
                    if (div_done) begin
                        div_pending <= 1'b0;
                        if (vert_idx == 2'd2)
                            state <= OUTPUT;    // All three vertices written
                        else
                            vert_idx <= vert_idx + 2'd1;
                    end
                end
                OUTPUT: begin
                    if (out_ready)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            tri_in_reg <= in_triangle;
        if (div_done) begin
            case (vert_idx)
                2'd0:    tri_proj_reg.v0 <= proj_vertex;
                2'd1:    tri_proj_reg.v1 <= proj_vertex;
                default: tri_proj_reg.v2 <= proj_vertex;
            endcase
        end
    end

    assign out_triangle = tri_proj_reg;

    // Downstream may sample the result any cycle while it waits
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_triangle))
        else $error("triangle_projector: output changed under back-pressure");

endmodule

/* logic/divu.sv */
`timescale 1ns/1ns

module divu #(
    parameter int WIDTH = 32,
    parameter int FBITS = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic             busy,
    output logic             done,
    output logic             valid,
    output logic             dbz,
    output logic             ovf,
    output logic [WIDTH-1:0] val
);

    localparam int QW = WIDTH + FBITS;      // Full quotient width
    localparam int CW = $clog2(QW + 1);

    logic [QW-1:0]    dividend;             // Shifted out MSB first
    logic [QW-1:0]    quot;
    logic [WIDTH-1:0] rem;
    logic [WIDTH-1:0] divisor;
    logic [CW-1:0]    iter;
    logic [WIDTH:0]   rem_shift;
    logic [WIDTH:0]   rem_diff;
    logic             fits;
    logic             stepping;

    // One restoring step: bring down the next bit, subtract if it fits
    always_comb begin
        rem_shift = {rem, dividend[QW-1]};
        rem_diff  = rem_shift - {1'b0, divisor};
        fits      = (rem_shift >= {1'b0, divisor});
    end

    assign stepping = busy && (iter != CW'(QW));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            valid <= 1'b0;
            dbz   <= 1'b0;
            ovf   <= 1'b0;
            iter  <= '0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                valid <= 1'b0;
                ovf   <= 1'b0;
                if (b == '0) begin
                    done <= 1'b1;           // Nothing to iterate
                    dbz  <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    dbz  <= 1'b0;
                    iter <= '0;
                end
            end else if (stepping) begin
                iter <= iter + CW'(1);
            end else if (busy) begin
                busy  <= 1'b0;
                done  <= 1'b1;
                ovf   <= |quot[QW-1:WIDTH]; // Integer part too wide for val
                valid <= ~|quot[QW-1:WIDTH];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            dividend <= {a, {FBITS{1'b0}}};
            divisor  <= b;
            quot     <= '0;
            rem      <= '0;
        end else if (stepping) begin
            dividend <= dividend << 1;
            quot     <= {quot[QW-2:0], fits};
            rem      <= fits ? rem_diff[WIDTH-1:0] : rem_shift[WIDTH-1:0];
        end else if (busy) begin
            val <= quot[WIDTH-1:0];
        end
    end

    // The caller must wait for done before issuing the next operand
    a_no_start_while_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy)
        else $error("divu: start issued while busy");

endmodule

/* logic/vertex_pkg.sv */
package vertex_pkg;

    // 8-bit per channel vertex color
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } color_t;

    // Camera space position, projected position after the projector
    typedef struct packed {
        math_pkg::q16_16_t x;
        math_pkg::q16_16_t y;
        math_pkg::q16_16_t z;   // Depth along the view axis
    } position_t;

    typedef struct packed {
        position_t pos;
        color_t    color;
    } vertex_t;

    // One triangle moves through the pipeline as a single word
    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

endpackage

/* logic/math_pkg.sv */
package math_pkg;

    // Signed fixed point, 16 integer bits and 16 fraction bits
    localparam int Q_WIDTH = 32;
    localparam int Q_FRAC  = 16;

    typedef logic signed [Q_WIDTH-1:0] q16_16_t;

    localparam q16_16_t Q_ONE = q16_16_t'(1) <<< Q_FRAC;  // 1.0

    // Perspective projection of one coordinate
    // f and coord are Q16.16, z_inv is the Q16.16 reciprocal of the depth.
    // The triple product carries 48 fraction bits, so dropping 32 of them
    // brings the result back to Q16.16. Upper bits are simply discarded
    function automatic q16_16_t project_q16_16(
        input q16_16_t f,
        input q16_16_t coord,
        input q16_16_t z_inv
    );
        logic signed [2*Q_WIDTH-1:0] f_coord;   // Q32.32
        logic signed [3*Q_WIDTH-1:0] product;   // Q48.48
        logic signed [3*Q_WIDTH-1:0] shifted;

        f_coord = f * coord;
        product = f_coord * z_inv;
        shifted = product >>> (2 * Q_FRAC);
        return shifted[Q_WIDTH-1:0];
    endfunction

endpackage
